/* common/tlb_pkg.sv */
package tlb_pkg;

    localparam int tlb_num    = 16;
    localparam int tlb_idx_w  = $clog2(tlb_num);

    localparam int vpn_w      = 20;
    localparam int vpn2_w     = vpn_w - 1;
    localparam int pfn_w      = 20;

    localparam int axi_addr_w = 8;
    localparam int axi_data_w = 32;

    // register map, byte offsets
    localparam logic [axi_addr_w-1:0] addr_index = 8'h00;
    localparam logic [axi_addr_w-1:0] addr_ehi   = 8'h04;
    localparam logic [axi_addr_w-1:0] addr_asid  = 8'h08;
    localparam logic [axi_addr_w-1:0] addr_elo0  = 8'h0C;
    localparam logic [axi_addr_w-1:0] addr_elo1  = 8'h10;
    localparam logic [axi_addr_w-1:0] addr_cmd   = 8'h14;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef enum logic [1:0] {
        fetch = 2'd0,
        load  = 2'd1,
        store = 2'd2
    } mem_type_e;

    // loongarch ecode values
    typedef enum logic [6:0] {
        exc_none = 7'h00,
        exc_pil  = 7'h01,
        exc_pis  = 7'h02,
        exc_pif  = 7'h03,
        exc_pme  = 7'h04,
        exc_ppi  = 7'h07,
        exc_tlbr = 7'h3F
    } exc_code_e;

    typedef enum logic [1:0] {
        cmd_nop = 2'd0,
        cmd_wr  = 2'd1,
        cmd_rd  = 2'd2
    } tlb_cmd_e;

    typedef struct packed {
        logic [pfn_w-1:0] pfn;
        logic [1:0]       mat;
        logic [1:0]       plv;
        logic             d;
        logic             v;
    } tlb_page_t;

    // one entry covers an even/odd pair of 4k pages
    typedef struct packed {
        logic [vpn2_w-1:0] vpn2;
        logic [7:0]        asid;
        logic [5:0]        ps;
        logic              e;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    typedef struct packed {
        logic [vpn_w-1:0] vpn;
        logic [7:0]       asid;
        logic [1:0]       plv;
        mem_type_e        mem_type;
    } tlb_req_t;

    typedef struct packed {
        logic      found;
        tlb_page_t page;
    } tlb_hit_t;

    typedef struct packed {
        logic             valid;
        logic [pfn_w-1:0] pfn;
        logic [1:0]       mat;
        exc_code_e        exc;
    } tlb_res_t;

endpackage

/* hw/mmu_top.sv */
module mmu_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [tlb_pkg::axi_addr_w-1:0]   awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [tlb_pkg::axi_data_w-1:0]   wdata,
    input  logic [tlb_pkg::axi_data_w/8-1:0] wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic [tlb_pkg::axi_addr_w-1:0]   araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output logic [tlb_pkg::axi_data_w-1:0]   rdata,
    output logic [1:0]                       rresp,
    output logic                             rvalid,
    input  logic                             rready,
    input  logic                             fetch_valid,
    input  tlb_pkg::tlb_req_t                fetch_req,
    input  logic                             data_valid,
    input  tlb_pkg::tlb_req_t                data_req,
    output tlb_pkg::tlb_res_t                fetch_res,
    output tlb_pkg::tlb_res_t                data_res
);
    import tlb_pkg::*;

    logic                 we;
    logic [tlb_idx_w-1:0] w_index;
    tlb_entry_t           w_entry;
    logic [tlb_idx_w-1:0] r_index;
    tlb_entry_t           r_entry;
    tlb_hit_t             fetch_hit;
    tlb_hit_t             data_hit;

    tlb_csr_port tlb_csr_port_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .we      (we),
        .w_index (w_index),
        .w_entry (w_entry),
        .r_index (r_index),
        .r_entry (r_entry)
    );

    // s0 serves fetch, s1 serves data
    tlb_array tlb_array_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (we),
        .w_index (w_index),
        .w_entry (w_entry),
        .r_index (r_index),
        .r_entry (r_entry),
        .s0_req  (fetch_req),
        .s1_req  (data_req),
        .s0_hit  (fetch_hit),
        .s1_hit  (data_hit)
    );

    tlb_check fetch_check (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (fetch_valid),
        .req       (fetch_req),
        .hit       (fetch_hit),
        .res       (fetch_res)
    );

    tlb_check data_check (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (data_valid),
        .req       (data_req),
        .hit       (data_hit),
        .res       (data_res)
    );

endmodule

/* hw/tlb_csr_port.sv */
module tlb_csr_port (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [tlb_pkg::axi_addr_w-1:0]   awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [tlb_pkg::axi_data_w-1:0]   wdata,
    input  logic [tlb_pkg::axi_data_w/8-1:0] wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic [tlb_pkg::axi_addr_w-1:0]   araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output logic [tlb_pkg::axi_data_w-1:0]   rdata,
    output logic [1:0]                       rresp,
    output logic                             rvalid,
    input  logic                             rready,
    output logic                             we,
    output logic [tlb_pkg::tlb_idx_w-1:0]    w_index,
    output tlb_pkg::tlb_entry_t              w_entry,
    output logic [tlb_pkg::tlb_idx_w-1:0]    r_index,
    input  tlb_pkg::tlb_entry_t              r_entry
);
    import tlb_pkg::*;

    logic [tlb_idx_w-1:0]  stage_index;
    tlb_entry_t            stage;
    logic                  rd_pend;
    logic                  wr_hs;
    logic                  rd_hs;
    logic [axi_data_w-1:0] wr_old;
    logic [axi_data_w-1:0] wr_word;
    tlb_cmd_e              wr_cmd;

    function automatic logic addr_mapped(logic [axi_addr_w-1:0] addr);
        return addr inside {addr_index, addr_ehi, addr_asid, addr_elo0, addr_elo1, addr_cmd};
    endfunction

    function automatic logic [axi_data_w-1:0] lo_word(tlb_page_t pg);
        return {pg.pfn, 6'b0, pg.mat, pg.plv, pg.d, pg.v};
    endfunction

    function automatic tlb_page_t lo_page(logic [axi_data_w-1:0] word);
        tlb_page_t pg;
        pg.pfn = word[31:12];
        pg.mat = word[5:4];
        pg.plv = word[3:2];
        pg.d   = word[1];
        pg.v   = word[0];
        return pg;
    endfunction

    // software view of the staging registers, cmd reads as zero
    function automatic logic [axi_data_w-1:0] reg_word(logic [axi_addr_w-1:0] addr,
                                                       logic [tlb_idx_w-1:0]  idx,
                                                       tlb_entry_t            ent);
        case (addr)
            addr_index: return {{(axi_data_w-tlb_idx_w){1'b0}}, idx};
            addr_ehi:   return {ent.vpn2, 5'b0, ent.ps, ent.g, ent.e};
            addr_asid:  return {24'b0, ent.asid};
            addr_elo0:  return lo_word(ent.page0);
            addr_elo1:  return lo_word(ent.page1);
            default:    return '0;
        endcase
    endfunction

    assign wr_hs   = awvalid && wvalid && !bvalid;
    assign awready = wr_hs;
    assign wready  = wr_hs;
    assign rd_hs   = arvalid && !rvalid;
    assign arready = !rvalid;

    assign w_index = stage_index;
    assign w_entry = stage;
    assign r_index = stage_index;

    // byte-lane merge
    always_comb begin
        wr_old = reg_word(awaddr, stage_index, stage);
        for (int b = 0; b < axi_data_w / 8; b++) begin
            wr_word[8*b +: 8] = wstrb[b] ? wdata[8*b +: 8] : wr_old[8*b +: 8];
        end
        wr_cmd = tlb_cmd_e'(wr_word[1:0]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid      <= 1'b0;
            rvalid      <= 1'b0;
            we          <= 1'b0;
            rd_pend     <= 1'b0;
            stage_index <= '0;
            stage       <= '0;
        end else begin
            we      <= 1'b0;
            rd_pend <= 1'b0;
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            // reload from the array one cycle after cmd_rd
            if (rd_pend) begin
                stage <= r_entry;
            end
            if (wr_hs) begin
                case (awaddr)
                    addr_index: stage_index <= wr_word[tlb_idx_w-1:0];
                    addr_ehi: begin
                        stage.vpn2 <= wr_word[31:13];
                        stage.ps   <= wr_word[7:2];
                        stage.g    <= wr_word[1];
                        stage.e    <= wr_word[0];
                    end
                    addr_asid:  stage.asid  <= wr_word[7:0];
                    addr_elo0:  stage.page0 <= lo_page(wr_word);
                    addr_elo1:  stage.page1 <= lo_page(wr_word);
                    addr_cmd: begin
                        case (wr_cmd)
                            cmd_wr:  we      <= 1'b1;
                            cmd_rd:  rd_pend <= 1'b1;
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp <= addr_mapped(awaddr) ? resp_okay : resp_slverr;
        end
        if (rd_hs) begin
            rdata <= reg_word(araddr, stage_index, stage);
            rresp <= addr_mapped(araddr) ? resp_okay : resp_slverr;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid);

    // a write pulse and a reload would race on the same entry
    a_we_not_reload: assert property (@(posedge clk) disable iff (!rst_n)
        !(we && rd_pend));

endmodule

/* mmu_top.f */
common/tlb_pkg.sv
hw/tlb_csr_port.sv
tlb/tlb_array.sv
tlb/tlb_check.sv
hw/mmu_top.sv
sim/mmu_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module mmu_tb -f mmu_top.f -o mmu_sim
./obj_dir/mmu_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* sim/mmu_tb.sv */
module mmu_tb;
    import tlb_pkg::*;

    localparam int wait_aw = 0;
    localparam int wait_b  = 1;
    localparam int wait_ar = 2;
    localparam int wait_r  = 3;

    localparam logic [31:0] ehi_mask = 32'hFFFF_E0FF;
    localparam logic [31:0] elo_mask = 32'hFFFF_F03F;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        fetch_valid;
    tlb_req_t    fetch_req;
    logic        data_valid;
    tlb_req_t    data_req;
    tlb_res_t    fetch_res;
    tlb_res_t    data_res;

    // reference model of the staging registers and the entries
    logic [3:0]  s_idx;
    logic [31:0] s_ehi;
    logic [31:0] s_asid;
    logic [31:0] s_elo0;
    logic [31:0] s_elo1;
    logic [31:0] m_ehi  [tlb_num];
    logic [31:0] m_asid [tlb_num];
    logic [31:0] m_elo0 [tlb_num];
    logic [31:0] m_elo1 [tlb_num];

    tlb_res_t    exp_fetch_q;
    tlb_res_t    exp_data_q;
    logic [1:0]  exp_bresp;
    logic [1:0]  exp_rresp;
    logic [31:0] exp_rdata;
    logic [31:0] rnd;
    logic [7:0]  asid_a;
    string       test_name;
    int          errors;
    int          timeouts;

    mmu_top mmu_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .fetch_valid (fetch_valid),
        .fetch_req   (fetch_req),
        .data_valid  (data_valid),
        .data_req    (data_req),
        .fetch_res   (fetch_res),
        .data_res    (data_res)
    );

    always #50 clk = ~clk;

    function automatic logic is_mapped(logic [7:0] addr);
        return addr inside {addr_index, addr_ehi, addr_asid, addr_elo0, addr_elo1, addr_cmd};
    endfunction

    function automatic logic [31:0] ehi_word(logic [18:0] vpn2, logic [5:0] ps,
                                             logic g, logic e);
        return {vpn2, 5'b0, ps, g, e};
    endfunction

    function automatic logic [31:0] elo_word(logic [19:0] pfn, logic [1:0] mat,
                                             logic [1:0] plv, logic d, logic v);
        return {pfn, 6'b0, mat, plv, d, v};
    endfunction

    // expected translation from the model entries
    function automatic tlb_res_t expect_res(logic valid, tlb_req_t req);
        tlb_res_t    r;
        logic [31:0] lo;
        r       = '0;
        r.valid = valid;
        r.exc   = exc_tlbr;
        for (int i = 0; i < tlb_num; i++) begin
            if (m_ehi[i][0] && (m_ehi[i][1] || (m_asid[i][7:0] == req.asid))
                    && (m_ehi[i][31:13] == req.vpn[19:1])) begin
                lo    = req.vpn[0] ? m_elo1[i] : m_elo0[i];
                r.pfn = lo[31:12];
                r.mat = lo[5:4];
                if (!lo[0]) begin
                    r.exc = (req.mem_type == fetch) ? exc_pif :
                            (req.mem_type == load)  ? exc_pil : exc_pis;
                end else if (req.plv > lo[3:2]) begin
                    r.exc = exc_ppi;
                end else if ((req.mem_type == store) && !lo[1]) begin
                    r.exc = exc_pme;
                end else begin
                    r.exc = exc_none;
                end
            end
        end
        return r;
    endfunction

    // pfn and mat only matter when the translation succeeds
    function automatic logic res_matches(tlb_res_t exp, tlb_res_t act);
        if (exp.valid != act.valid) begin
            return 1'b0;
        end
        if (!exp.valid) begin
            return 1'b1;
        end
        if (exp.exc != act.exc) begin
            return 1'b0;
        end
        return (exp.exc != exc_none) || ((exp.pfn == act.pfn) && (exp.mat == act.mat));
    endfunction

    function automatic logic [31:0] reg_expect(logic [7:0] addr);
        case (addr)
            addr_index: return {28'b0, s_idx};
            addr_ehi:   return s_ehi;
            addr_asid:  return s_asid;
            addr_elo0:  return s_elo0;
            addr_elo1:  return s_elo1;
            default:    return 32'b0;
        endcase
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_fetch_q <= '0;
            exp_data_q  <= '0;
        end else begin
            exp_fetch_q <= expect_res(fetch_valid, fetch_req);
            exp_data_q  <= expect_res(data_valid, data_req);
        end
    end

    a_reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> !bvalid && !rvalid && !fetch_res.valid && !data_res.valid)
    else begin
        errors++;
        $display("response or result valid was high right after reset");
    end

    a_fetch_res: assert property (@(posedge clk) disable iff (!rst_n)
        res_matches(exp_fetch_q, fetch_res))
    else begin
        errors++;
        $display("Error %s: fetch_res expected %h actual %h", test_name,
                 $sampled(exp_fetch_q), $sampled(fetch_res));
    end

    a_data_res: assert property (@(posedge clk) disable iff (!rst_n)
        res_matches(exp_data_q, data_res))
    else begin
        errors++;
        $display("Error %s: data_res expected %h actual %h", test_name,
                 $sampled(exp_data_q), $sampled(data_res));
    end

    a_bresp: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && bready |-> bresp == exp_bresp)
    else begin
        errors++;
        $display("Error %s: bresp expected %h actual %h", test_name,
                 $sampled(exp_bresp), $sampled(bresp));
    end

    a_rresp: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && rready |-> rresp == exp_rresp)
    else begin
        errors++;
        $display("Error %s: rresp expected %h actual %h", test_name,
                 $sampled(exp_rresp), $sampled(rresp));
    end

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && rready && (exp_rresp == resp_okay) |-> rdata == exp_rdata)
    else begin
        errors++;
        $display("Error %s: rdata expected %h actual %h", test_name,
                 $sampled(exp_rdata), $sampled(rdata));
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
    else begin
        errors++;
        $display("in %s bvalid dropped while bready was low", test_name);
    end

    a_no_accept: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid |-> !awready && !wready)
    else begin
        errors++;
        $display("in %s a write was accepted while a response was pending", test_name);
    end

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic wait_for(input int which);
        logic seen;
        int   cnt;
        seen = 1'b0;
        cnt  = 0;
        while (!seen && cnt < 50) begin
            @(negedge clk);
            case (which)
                wait_aw: seen = awready && wready;
                wait_b:  seen = bvalid && bready;
                wait_ar: seen = arready && arvalid;
                default: seen = rvalid && rready;
            endcase
            next_cycle();
            cnt++;
        end
        if (!seen) begin
            timeouts++;
            case (which)
                wait_aw: $display("in %s the write was never accepted", test_name);
                wait_b:  $display("in %s the write response never came", test_name);
                wait_ar: $display("in %s the read address was never accepted", test_name);
                default: $display("in %s the read response never came", test_name);
            endcase
        end
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        exp_bresp = is_mapped(addr) ? resp_okay : resp_slverr;
        awaddr    = addr;
        wdata     = data;
        wstrb     = 4'hF;
        awvalid   = 1'b1;
        wvalid    = 1'b1;
        bready    = 1'b1;
        wait_for(wait_aw);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_for(wait_b);
        case (addr)
            addr_index: s_idx  = data[3:0];
            addr_ehi:   s_ehi  = data & ehi_mask;
            addr_asid:  s_asid = data & 32'h0000_00FF;
            addr_elo0:  s_elo0 = data & elo_mask;
            addr_elo1:  s_elo1 = data & elo_mask;
            addr_cmd: begin
                if (data[1:0] == cmd_wr) begin
                    m_ehi[s_idx]  = s_ehi;
                    m_asid[s_idx] = s_asid;
                    m_elo0[s_idx] = s_elo0;
                    m_elo1[s_idx] = s_elo1;
                end else if (data[1:0] == cmd_rd) begin
                    s_ehi  = m_ehi[s_idx];
                    s_asid = m_asid[s_idx];
                    s_elo0 = m_elo0[s_idx];
                    s_elo1 = m_elo1[s_idx];
                end
            end
            default: ;
        endcase
    endtask

    task automatic reg_read(input logic [7:0] addr);
        exp_rresp = is_mapped(addr) ? resp_okay : resp_slverr;
        exp_rdata = reg_expect(addr);
        araddr    = addr;
        arvalid   = 1'b1;
        rready    = 1'b1;
        wait_for(wait_ar);
        arvalid = 1'b0;
        wait_for(wait_r);
    endtask

    task automatic write_entry(input logic [3:0] idx, input logic [31:0] ehi,
                               input logic [7:0] asid, input logic [31:0] elo0,
                               input logic [31:0] elo1);
        reg_write(addr_index, {28'b0, idx});
        reg_write(addr_ehi, ehi);
        reg_write(addr_asid, {24'b0, asid});
        reg_write(addr_elo0, elo0);
        reg_write(addr_elo1, elo1);
        reg_write(addr_cmd, 32'd1);
    endtask

    task automatic search(input logic on_data, input logic [19:0] vpn,
                          input logic [7:0] asid, input logic [1:0] plv, input mem_type_e mt);
        tlb_req_t r;
        r = '{vpn: vpn, asid: asid, plv: plv, mem_type: mt};
        if (on_data) begin
            data_req   = r;
            data_valid = 1'b1;
        end else begin
            fetch_req   = r;
            fetch_valid = 1'b1;
        end
    endtask

    // let the last results reach their checks
    task automatic search_idle();
        fetch_valid = 1'b0;
        data_valid  = 1'b0;
        next_cycle();
        next_cycle();
    endtask

    task automatic check_backpressure();
        exp_bresp = resp_okay;
        awaddr    = addr_asid;
        wdata     = 32'h0000_00A5;
        wstrb     = 4'hF;
        awvalid   = 1'b1;
        wvalid    = 1'b1;
        bready    = 1'b0;
        wait_for(wait_aw);
        s_asid = 32'h0000_00A5;
        wdata  = 32'h0000_003C;
        repeat (4) begin
            next_cycle();
        end
        bready = 1'b1;
        wait_for(wait_b);
        wait_for(wait_aw);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_for(wait_b);
        s_asid = 32'h0000_003C;
        reg_read(addr_asid);
    endtask

    initial begin
        rst_n       = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        data_valid  = 1'b0;
        data_req    = '0;
        errors      = 0;
        timeouts    = 0;
        s_idx       = '0;
        s_ehi       = '0;
        s_asid      = '0;
        s_elo0      = '0;
        s_elo1      = '0;
        for (int i = 0; i < tlb_num; i++) begin
            m_ehi[i]  = '0;
            m_asid[i] = '0;
            m_elo0[i] = '0;
            m_elo1[i] = '0;
        end
        void'($urandom(77));
        repeat (5) begin
            @(posedge clk);
        end
        #5;
        rst_n = 1'b1;

        test_name = "reset_state";
        rnd = $urandom;
        search(1'b0, rnd[19:0], rnd[27:20], 2'd0, fetch);
        search(1'b1, rnd[31:12], rnd[7:0], 2'd3, store);
        next_cycle();
        search_idle();

        test_name = "write_read_back";
        rnd = $urandom;
        reg_write(addr_index, rnd);
        // top vpn2 bit set keeps this entry away from the search tests
        rnd = $urandom;
        reg_write(addr_ehi, rnd | 32'h8000_0001);
        reg_write(addr_asid, $urandom);
        reg_write(addr_elo0, $urandom);
        reg_write(addr_elo1, $urandom);
        reg_write(addr_cmd, 32'd1);
        reg_write(addr_ehi, 32'd0);
        reg_write(addr_asid, 32'd0);
        reg_write(addr_elo0, 32'd0);
        reg_write(addr_elo1, 32'd0);
        reg_write(addr_cmd, 32'd2);
        reg_read(addr_index);
        reg_read(addr_ehi);
        reg_read(addr_asid);
        reg_read(addr_elo0);
        reg_read(addr_elo1);

        test_name = "search_hit";
        rnd = $urandom;
        asid_a = rnd[7:0];
        write_entry(4'd3, ehi_word(19'h00123, 6'd12, 1'b0, 1'b1), asid_a,
                    elo_word(rnd[31:12], 2'd1, 2'd3, 1'b1, 1'b1),
                    elo_word(rnd[19:0] ^ 20'h5A5A5, 2'd2, 2'd3, 1'b1, 1'b1));
        search(1'b0, {19'h00123, 1'b0}, asid_a, 2'd0, fetch);
        search(1'b1, {19'h00123, 1'b1}, asid_a, 2'd0, load);
        next_cycle();
        search(1'b0, {19'h00123, 1'b1}, asid_a, 2'd1, fetch);
        search(1'b1, {19'h00123, 1'b0}, asid_a, 2'd2, store);
        next_cycle();
        search(1'b0, {19'h00123, 1'b0}, asid_a ^ 8'h01, 2'd0, fetch);
        search(1'b1, {19'h00123, 1'b1}, asid_a ^ 8'h80, 2'd0, load);
        next_cycle();
        search_idle();
        rnd = $urandom;
        write_entry(4'd7, ehi_word(19'h00456, 6'd12, 1'b1, 1'b1), asid_a,
                    elo_word(rnd[31:12], 2'd3, 2'd3, 1'b1, 1'b1),
                    elo_word(rnd[23:4], 2'd0, 2'd3, 1'b1, 1'b1));
        search(1'b0, {19'h00456, 1'b1}, ~asid_a, 2'd3, fetch);
        search(1'b1, {19'h00456, 1'b0}, ~asid_a, 2'd3, load);
        next_cycle();
        search_idle();

        test_name = "invalid_page";
        write_entry(4'd9, ehi_word(19'h00789, 6'd12, 1'b1, 1'b1), 8'h00,
                    elo_word(20'h11111, 2'd1, 2'd3, 1'b1, 1'b0),
                    elo_word(20'h22222, 2'd1, 2'd3, 1'b1, 1'b0));
        search(1'b0, {19'h00789, 1'b0}, asid_a, 2'd0, fetch);
        search(1'b1, {19'h00789, 1'b0}, asid_a, 2'd0, load);
        next_cycle();
        search(1'b1, {19'h00789, 1'b1}, asid_a, 2'd0, store);
        next_cycle();
        search_idle();

        test_name = "privilege_modify";
        write_entry(4'd12, ehi_word(19'h00ABC, 6'd12, 1'b1, 1'b1), 8'h00,
                    elo_word(20'h33333, 2'd1, 2'd0, 1'b1, 1'b1),
                    elo_word(20'h44444, 2'd2, 2'd3, 1'b0, 1'b1));
        search(1'b0, {19'h00ABC, 1'b0}, asid_a, 2'd3, fetch);
        search(1'b1, {19'h00ABC, 1'b1}, asid_a, 2'd0, store);
        next_cycle();
        search(1'b1, {19'h00ABC, 1'b1}, asid_a, 2'd0, load);
        next_cycle();
        search(1'b1, {19'h00ABC, 1'b0}, asid_a, 2'd3, store);
        next_cycle();
        search_idle();

        test_name = "axi_response";
        reg_write(8'h20, 32'hDEAD_BEEF);
        reg_read(8'h20);
        reg_read(addr_cmd);
        check_backpressure();
        next_cycle();

        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tlb/tlb_array.sv */
module tlb_array (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          we,
    input  logic [tlb_pkg::tlb_idx_w-1:0] w_index,
    input  tlb_pkg::tlb_entry_t           w_entry,
    input  logic [tlb_pkg::tlb_idx_w-1:0] r_index,
    output tlb_pkg::tlb_entry_t           r_entry,
    input  tlb_pkg::tlb_req_t             s0_req,
    input  tlb_pkg::tlb_req_t             s1_req,
    output tlb_pkg::tlb_hit_t             s0_hit,
    output tlb_pkg::tlb_hit_t             s1_hit
);
    import tlb_pkg::*;

    tlb_entry_t         tlb_mem [tlb_num];
    logic [tlb_num-1:0] tlb_e;
    logic [tlb_num-1:0] s0_match;
    logic [tlb_num-1:0] s1_match;

    // page size is not used, pairs are always 4k
    function automatic logic entry_match(tlb_entry_t ent, logic exist, tlb_req_t req);
        return exist
            && (ent.g || (ent.asid == req.asid))
            && (ent.vpn2 == req.vpn[vpn_w-1:1]);
    endfunction

    function automatic tlb_page_t pick_page(tlb_entry_t ent, logic odd);
        return odd ? ent.page1 : ent.page0;
    endfunction

    always_ff @(posedge clk) begin
        if (we) begin
            tlb_mem[w_index] <= w_entry;
        end
    end

    // exist bits live apart so reset only touches them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tlb_e <= '0;
        end else if (we) begin
            tlb_e[w_index] <= w_entry.e;
        end
    end

    always_comb begin
        r_entry   = tlb_mem[r_index];
        r_entry.e = tlb_e[r_index];
    end

    for (genvar i = 0; i < tlb_num; i++) begin : g_match
        assign s0_match[i] = entry_match(tlb_mem[i], tlb_e[i], s0_req);
        assign s1_match[i] = entry_match(tlb_mem[i], tlb_e[i], s1_req);
    end

    always_comb begin
        s0_hit       = '0;
        s1_hit       = '0;
        s0_hit.found = |s0_match;
        s1_hit.found = |s1_match;
        for (int i = 0; i < tlb_num; i++) begin
            if (s0_match[i]) begin
                s0_hit.page = pick_page(tlb_mem[i], s0_req.vpn[0]);
            end
            if (s1_match[i]) begin
                s1_hit.page = pick_page(tlb_mem[i], s1_req.vpn[0]);
            end
        end
    end

    // software must not write overlapping entries
    a_s0_single: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(s0_match));

    a_s1_single: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(s1_match));

endmodule

/* tlb/tlb_check.sv */
module tlb_check (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  tlb_pkg::tlb_req_t req,
    input  tlb_pkg::tlb_hit_t hit,
    output tlb_pkg::tlb_res_t res
);
    import tlb_pkg::*;

    logic             res_valid;
    logic [pfn_w-1:0] res_pfn;
    logic [1:0]       res_mat;
    exc_code_e        res_exc;
    exc_code_e        next_exc;

    // refill > invalid > privilege > modify
    always_comb begin
        if (!hit.found) begin
            next_exc = exc_tlbr;
        end else if (!hit.page.v) begin
            case (req.mem_type)
                fetch:   next_exc = exc_pif;
                load:    next_exc = exc_pil;
                default: next_exc = exc_pis;
            endcase
        end else if (req.plv > hit.page.plv) begin
            next_exc = exc_ppi;
        end else if ((req.mem_type == store) && !hit.page.d) begin
            next_exc = exc_pme;
        end else begin
            next_exc = exc_none;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        res_pfn <= hit.page.pfn;
        res_mat <= hit.page.mat;
        res_exc <= next_exc;
    end

    assign res = '{valid: res_valid, pfn: res_pfn, mat: res_mat, exc: res_exc};

    a_exc_defined: assert property (@(posedge clk) disable iff (!rst_n)
        res.valid |-> res.exc inside {exc_none, exc_tlbr, exc_pif, exc_pil,
                                      exc_pis, exc_ppi, exc_pme});

endmodule
